// ==== wb_stage_top.f ====
src/wb_pkg.sv
src/memwb_register.sv
src/wb_select.sv
src/int_regfile.sv
src/fp_regfile.sv
src/fflags_csr.sv
src/wb_stage_top.sv
test/wb_stage_asserts.sv
test/wb_stage_tb.sv

// ==== test/wb_stage_tb.sv ====
// Write-back stage testbench
// Random memory-stage entries checked against a model of both
// register files and the accrued fflags register
`timescale 1ns/10ps

module wb_stage_tb
  import wb_pkg::*;
();

  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 400;
  localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST + 100;

  logic clk;
  logic reset_n;
  logic [XLEN-1:0] alu_result_in, mem_read_data_in, pc_plus_4_in, csr_rdata_in;
  logic [XLEN-1:0] mul_div_result_in, atomic_result_in, int_result_fp_in;
  logic [FLEN-1:0] fp_mem_read_data_in, fp_result_in;
  logic [REG_ADDR_W-1:0] rd_addr_in, fp_rd_addr_in;
  logic [WB_SEL_W-1:0] wb_sel_in;
  logic reg_write_in, valid_in, fp_reg_write_in, int_reg_write_fp_in, fp_fmt_in;
  logic fp_flag_nv_in, fp_flag_dz_in, fp_flag_of_in, fp_flag_uf_in, fp_flag_nx_in;
  logic [REG_ADDR_W-1:0] int_rs1_addr, int_rs2_addr, fp_rs_addr;
  logic [XLEN-1:0] int_rs1_data, int_rs2_data;
  logic [FLEN-1:0] fp_rs_data;
  logic fflags_wr_en;
  logic [NUM_FFLAGS-1:0] fflags_wr_data, fflags;

  // Reference model state
  logic [XLEN-1:0] m_int [32];
  logic [FLEN-1:0] m_fp [32];
  logic [NUM_FFLAGS-1:0] m_fflags;

  // Model of the entry held in the MEM/WB register
  logic p_valid, p_int_we, p_fp_we;
  logic [REG_ADDR_W-1:0] p_int_addr, p_fp_addr;
  logic [XLEN-1:0] p_int_data;
  logic [FLEN-1:0] p_fp_data;
  logic [NUM_FFLAGS-1:0] p_flags;

  logic [REG_ADDR_W-1:0] last_int_addr, last_fp_addr;  // Targets of the latest write-back
  logic [REG_ADDR_W-1:0] hot_int_addr, hot_fp_addr;
  logic [31:0] lcg_state;
  int cycle_count = 0;

  wb_stage_top u_dut (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout");
      $display("Test FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper halves only, the low LCG bits repeat too quickly
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic logic [31:0] rand_below(input int n);
    logic [31:0] r;
    r = rand_word();
    return r % n;
  endfunction

  function automatic logic [XLEN-1:0] expected_int_data(input logic [WB_SEL_W-1:0] sel);
    case (sel)
      WB_SEL_ALU:    return alu_result_in;
      WB_SEL_MEM:    return mem_read_data_in;
      WB_SEL_PC4:    return pc_plus_4_in;
      WB_SEL_CSR:    return csr_rdata_in;
      WB_SEL_MULDIV: return mul_div_result_in;
      WB_SEL_ATOMIC: return atomic_result_in;
      WB_SEL_FPINT:  return int_result_fp_in;
      default:       return '0;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h, expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Model of the DUT inputs as the MEM/WB register captures them
  task automatic capture_entry();
    fp_word_u w;
    p_valid    = valid_in;
    p_int_we   = valid_in && (reg_write_in || int_reg_write_fp_in);
    p_int_addr = rd_addr_in;
    p_int_data = expected_int_data(wb_sel_in);
    p_fp_we    = valid_in && fp_reg_write_in;
    p_fp_addr  = fp_rd_addr_in;
    w.dbl      = (wb_sel_in == WB_SEL_MEM) ? fp_mem_read_data_in : fp_result_in;
    if (!fp_fmt_in) begin
      w.sgl.box = '1;
    end
    p_fp_data = w.dbl;
    p_flags   = {fp_flag_nv_in, fp_flag_dz_in, fp_flag_of_in, fp_flag_uf_in, fp_flag_nx_in};
  endtask

  // Write-back of the registered entry plus any software fflags write
  task automatic apply_entry();
    logic [NUM_FFLAGS-1:0] f;
    f = fflags_wr_en ? fflags_wr_data : m_fflags;
    if (p_valid) begin
      f = f | p_flags;
    end
    m_fflags = f;
    if (p_int_we && (p_int_addr != 0)) begin
      m_int[p_int_addr] = p_int_data;
    end
    if (p_fp_we) begin
      m_fp[p_fp_addr] = p_fp_data;
    end
    last_int_addr = p_int_addr;
    last_fp_addr  = p_fp_addr;
  endtask

  task automatic drive_entry(input int test, input int idx);
    alu_result_in       = rand_word();
    mem_read_data_in    = rand_word();
    pc_plus_4_in        = rand_word();
    csr_rdata_in        = rand_word();
    mul_div_result_in   = rand_word();
    atomic_result_in    = rand_word();
    int_result_fp_in    = rand_word();
    fp_mem_read_data_in = {rand_word(), rand_word()};
    fp_result_in        = {rand_word(), rand_word()};
    rd_addr_in          = rand_below(32);
    fp_rd_addr_in       = rand_below(32);
    wb_sel_in           = rand_below(8);  // Code 7 included
    fp_fmt_in           = rand_below(2);
    valid_in            = 1'b1;
    reg_write_in        = rand_below(2);
    int_reg_write_fp_in = rand_below(2);
    fp_reg_write_in     = rand_below(2);
    {fp_flag_nv_in, fp_flag_dz_in, fp_flag_of_in, fp_flag_uf_in, fp_flag_nx_in} = '0;
    fflags_wr_en        = 1'b0;
    fflags_wr_data      = rand_below(32);
    int_rs1_addr        = rand_below(32);
    int_rs2_addr        = last_int_addr;  // Reads back the register just written
    fp_rs_addr          = rand_below(2) ? last_fp_addr : rand_below(32);
    case (test)
      1: begin  // Bubbles only, sweep every address
        valid_in     = 1'b0;
        int_rs1_addr = idx[4:0];
        fp_rs_addr   = idx[4:0];
      end
      2: fp_reg_write_in = 1'b0;
      3: begin
        valid_in        = rand_below(2);
        reg_write_in    = 1'b1;
        fp_reg_write_in = 1'b1;
        if (rand_below(2)) begin
          rd_addr_in = '0;
        end
        {fp_flag_nv_in, fp_flag_dz_in, fp_flag_of_in, fp_flag_uf_in, fp_flag_nx_in} =
          rand_below(32);
      end
      4: begin
        reg_write_in        = 1'b0;
        int_reg_write_fp_in = 1'b0;
        fp_reg_write_in     = 1'b1;
      end
      5: begin
        valid_in     = rand_below(2);
        fflags_wr_en = (rand_below(4) == 0);
        {fp_flag_nv_in, fp_flag_dz_in, fp_flag_of_in, fp_flag_uf_in, fp_flag_nx_in} =
          rand_below(32);
      end
      default: begin  // Same targets every cycle
        valid_in        = (rand_below(8) != 0);
        reg_write_in    = 1'b1;
        fp_reg_write_in = 1'b1;
        rd_addr_in      = hot_int_addr;
        fp_rd_addr_in   = hot_fp_addr;
        int_rs2_addr    = hot_int_addr;
        fp_rs_addr      = hot_fp_addr;
      end
    endcase
  endtask

  task automatic check_reads();
    check_value($sformatf("x%0d on rs1", int_rs1_addr), int_rs1_data, m_int[int_rs1_addr]);
    check_value($sformatf("x%0d on rs2", int_rs2_addr), int_rs2_data, m_int[int_rs2_addr]);
    check_value($sformatf("f%0d", fp_rs_addr), fp_rs_data, m_fp[fp_rs_addr]);
    check_value("fflags", fflags, m_fflags);
  endtask

  // Model updates at the edge, new inputs 1 ns later, reads checked mid-cycle
  task automatic step_cycle(input int test, input int idx);
    @(posedge clk);
    apply_entry();
    capture_entry();
    #1;
    drive_entry(test, idx);
    #4;
    check_reads();
  endtask

  initial begin
    clk       = 1'b0;
    reset_n   = 1'b1;
    lcg_state = 32'd92;
    {alu_result_in, mem_read_data_in, pc_plus_4_in, csr_rdata_in} = '0;
    {mul_div_result_in, atomic_result_in, int_result_fp_in} = '0;
    {fp_mem_read_data_in, fp_result_in, rd_addr_in, fp_rd_addr_in, wb_sel_in} = '0;
    {reg_write_in, valid_in, fp_reg_write_in, int_reg_write_fp_in, fp_fmt_in} = '0;
    {fp_flag_nv_in, fp_flag_dz_in, fp_flag_of_in, fp_flag_uf_in, fp_flag_nx_in} = '0;
    {int_rs1_addr, int_rs2_addr, fp_rs_addr, fflags_wr_en, fflags_wr_data} = '0;
    for (int i = 0; i < 32; i++) begin
      m_int[i] = '0;
      m_fp[i]  = '0;
    end
    m_fflags = '0;
    {p_valid, p_int_we, p_fp_we, p_int_addr, p_fp_addr, p_int_data, p_fp_data, p_flags} = '0;
    {last_int_addr, last_fp_addr} = '0;
    #1 reset_n = 1'b0;  // Falling edge clears the pipe before the first rising edge
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      hot_int_addr = rand_below(31) + 1;
      hot_fp_addr  = rand_below(32);
      for (int i = 0; i < CYCLES_PER_TEST; i++) begin
        step_cycle(t, i);
      end
    end
    if (u_dut.u_asserts.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("%0d assertion failures", u_dut.u_asserts.fail_count);
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== test/wb_stage_asserts.sv ====
// Write-back stage assertions
// Write enable and x0 read properties, bound into the top level
`timescale 1ns/10ps

module wb_stage_asserts
  import wb_pkg::*;
(
  input logic                  clk,
  input logic                  reset_n,
  input logic                  int_we,
  input logic                  fp_we,
  input logic                  valid_in,
  input logic [REG_ADDR_W-1:0] int_rs1_addr,
  input logic [XLEN-1:0]       int_rs1_data
);

  int fail_count = 0;  // Checked by the testbench at the end of the run

  // Nothing retires while the stage is held in reset
  a_we_off_in_reset: assert property (@(posedge clk) !reset_n |-> (!int_we && !fp_we))
    else begin
      fail_count++;
      $error("Write enable high during reset");
    end

  // An FP write retires only an entry that entered the stage as valid
  a_fp_we_valid: assert property (@(posedge clk) disable iff (!reset_n)
      fp_we |-> $past(valid_in))
    else begin
      fail_count++;
      $error("fp_we without a valid entry");
    end

  a_x0_zero: assert property (@(posedge clk) (int_rs1_addr == '0) |-> (int_rs1_data == '0))
    else begin
      fail_count++;
      $error("x0 read nonzero");
    end

endmodule

bind wb_stage_top wb_stage_asserts u_asserts (
  .clk          (clk),
  .reset_n      (reset_n),
  .int_we       (int_we),
  .fp_we        (fp_we),
  .valid_in     (valid_in),
  .int_rs1_addr (int_rs1_addr),
  .int_rs1_data (int_rs1_data)
);

// ==== src/wb_stage_top.sv ====
// Write-back stage top
// MEM/WB register feeding the write-back selector, both register files
// and the accrued fflags register
`timescale 1ns/10ps

module wb_stage_top
  import wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,

  // Memory-stage results
  input  logic [XLEN-1:0]       alu_result_in,
  input  logic [XLEN-1:0]       mem_read_data_in,
  input  logic [FLEN-1:0]       fp_mem_read_data_in,
  input  logic [REG_ADDR_W-1:0] rd_addr_in,
  input  logic [XLEN-1:0]       pc_plus_4_in,
  input  logic                  reg_write_in,
  input  logic [WB_SEL_W-1:0]   wb_sel_in,
  input  logic                  valid_in,
  input  logic [XLEN-1:0]       mul_div_result_in,
  input  logic [XLEN-1:0]       atomic_result_in,
  input  logic [FLEN-1:0]       fp_result_in,
  input  logic [XLEN-1:0]       int_result_fp_in,
  input  logic [REG_ADDR_W-1:0] fp_rd_addr_in,
  input  logic                  fp_reg_write_in,
  input  logic                  int_reg_write_fp_in,
  input  logic                  fp_flag_nv_in,
  input  logic                  fp_flag_dz_in,
  input  logic                  fp_flag_of_in,
  input  logic                  fp_flag_uf_in,
  input  logic                  fp_flag_nx_in,
  input  logic                  fp_fmt_in,
  input  logic [XLEN-1:0]       csr_rdata_in,

  // Register file read ports
  input  logic [REG_ADDR_W-1:0] int_rs1_addr,
  input  logic [REG_ADDR_W-1:0] int_rs2_addr,
  input  logic [REG_ADDR_W-1:0] fp_rs_addr,
  output logic [XLEN-1:0]       int_rs1_data,
  output logic [XLEN-1:0]       int_rs2_data,
  output logic [FLEN-1:0]       fp_rs_data,

  // fflags CSR access
  input  logic                  fflags_wr_en,
  input  logic [NUM_FFLAGS-1:0] fflags_wr_data,
  output logic [NUM_FFLAGS-1:0] fflags
);

  // Registered memory-stage values
  logic [XLEN-1:0]       alu_result;
  logic [XLEN-1:0]       mem_read_data;
  logic [FLEN-1:0]       fp_mem_read_data;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       pc_plus_4;
  logic                  reg_write;
  logic [WB_SEL_W-1:0]   wb_sel;
  logic                  valid;
  logic [XLEN-1:0]       mul_div_result;
  logic [XLEN-1:0]       atomic_result;
  logic [FLEN-1:0]       fp_result;
  logic [XLEN-1:0]       int_result_fp;
  logic [REG_ADDR_W-1:0] fp_rd_addr;
  logic                  fp_reg_write;
  logic                  int_reg_write_fp;
  logic                  fp_flag_nv;
  logic                  fp_flag_dz;
  logic                  fp_flag_of;
  logic                  fp_flag_uf;
  logic                  fp_flag_nx;
  logic                  fp_fmt;
  logic [XLEN-1:0]       csr_rdata;

  // Register file write ports
  logic                  int_we;
  logic [REG_ADDR_W-1:0] int_waddr;
  logic [XLEN-1:0]       int_wdata;
  logic                  fp_we;
  logic [REG_ADDR_W-1:0] fp_waddr;
  logic [FLEN-1:0]       fp_wdata;

  memwb_register u_memwb (
    .clk                  (clk),
    .reset_n              (reset_n),
    .alu_result_in        (alu_result_in),
    .mem_read_data_in     (mem_read_data_in),
    .fp_mem_read_data_in  (fp_mem_read_data_in),
    .rd_addr_in           (rd_addr_in),
    .pc_plus_4_in         (pc_plus_4_in),
    .reg_write_in         (reg_write_in),
    .wb_sel_in            (wb_sel_in),
    .valid_in             (valid_in),
    .mul_div_result_in    (mul_div_result_in),
    .atomic_result_in     (atomic_result_in),
    .fp_result_in         (fp_result_in),
    .int_result_fp_in     (int_result_fp_in),
    .fp_rd_addr_in        (fp_rd_addr_in),
    .fp_reg_write_in      (fp_reg_write_in),
    .int_reg_write_fp_in  (int_reg_write_fp_in),
    .fp_flag_nv_in        (fp_flag_nv_in),
    .fp_flag_dz_in        (fp_flag_dz_in),
    .fp_flag_of_in        (fp_flag_of_in),
    .fp_flag_uf_in        (fp_flag_uf_in),
    .fp_flag_nx_in        (fp_flag_nx_in),
    .fp_fmt_in            (fp_fmt_in),
    .csr_rdata_in         (csr_rdata_in),
    .alu_result_out       (alu_result),
    .mem_read_data_out    (mem_read_data),
    .fp_mem_read_data_out (fp_mem_read_data),
    .rd_addr_out          (rd_addr),
    .pc_plus_4_out        (pc_plus_4),
    .reg_write_out        (reg_write),
    .wb_sel_out           (wb_sel),
    .valid_out            (valid),
    .mul_div_result_out   (mul_div_result),
    .atomic_result_out    (atomic_result),
    .fp_result_out        (fp_result),
    .int_result_fp_out    (int_result_fp),
    .fp_rd_addr_out       (fp_rd_addr),
    .fp_reg_write_out     (fp_reg_write),
    .int_reg_write_fp_out (int_reg_write_fp),
    .fp_flag_nv_out       (fp_flag_nv),
    .fp_flag_dz_out       (fp_flag_dz),
    .fp_flag_of_out       (fp_flag_of),
    .fp_flag_uf_out       (fp_flag_uf),
    .fp_flag_nx_out       (fp_flag_nx),
    .fp_fmt_out           (fp_fmt),
    .csr_rdata_out        (csr_rdata)
  );

  wb_select u_wb_select (
    .alu_result       (alu_result),
    .mem_read_data    (mem_read_data),
    .fp_mem_read_data (fp_mem_read_data),
    .rd_addr          (rd_addr),
    .pc_plus_4        (pc_plus_4),
    .reg_write        (reg_write),
    .wb_sel           (wb_sel),
    .valid            (valid),
    .mul_div_result   (mul_div_result),
    .atomic_result    (atomic_result),
    .fp_result        (fp_result),
    .int_result_fp    (int_result_fp),
    .fp_rd_addr       (fp_rd_addr),
    .fp_reg_write     (fp_reg_write),
    .int_reg_write_fp (int_reg_write_fp),
    .fp_fmt           (fp_fmt),
    .csr_rdata        (csr_rdata),
    .int_we           (int_we),
    .int_waddr        (int_waddr),
    .int_wdata        (int_wdata),
    .fp_we            (fp_we),
    .fp_waddr         (fp_waddr),
    .fp_wdata         (fp_wdata)
  );

  int_regfile u_int_rf (
    .clk      (clk),
    .reset_n  (reset_n),
    .we       (int_we),
    .waddr    (int_waddr),
    .wdata    (int_wdata),
    .rs1_addr (int_rs1_addr),
    .rs2_addr (int_rs2_addr),
    .rs1_data (int_rs1_data),
    .rs2_data (int_rs2_data)
  );

  fp_regfile u_fp_rf (
    .clk     (clk),
    .reset_n (reset_n),
    .we      (fp_we),
    .waddr   (fp_waddr),
    .wdata   (fp_wdata),
    .rs_addr (fp_rs_addr),
    .rs_data (fp_rs_data)
  );

  // Flags come from the registered entry, so they land with the RF write
  fflags_csr u_fflags (
    .clk     (clk),
    .reset_n (reset_n),
    .valid   (valid),
    .flag_nv (fp_flag_nv),
    .flag_dz (fp_flag_dz),
    .flag_of (fp_flag_of),
    .flag_uf (fp_flag_uf),
    .flag_nx (fp_flag_nx),
    .wr_en   (fflags_wr_en),
    .wr_data (fflags_wr_data),
    .fflags  (fflags)
  );

endmodule

// ==== src/fflags_csr.sv ====
// fflags accrued exception register
// Sticky NV/DZ/OF/UF/NX flags, ORed in as FP instructions retire,
// with a software write port that merges with same-cycle accrual
`timescale 1ns/10ps

module fflags_csr
  import wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  valid,    // Retiring entry this cycle
  input  logic                  flag_nv,
  input  logic                  flag_dz,
  input  logic                  flag_of,
  input  logic                  flag_uf,
  input  logic                  flag_nx,
  input  logic                  wr_en,
  input  logic [NUM_FFLAGS-1:0] wr_data,
  output logic [NUM_FFLAGS-1:0] fflags
);

  logic [NUM_FFLAGS-1:0] retire_flags;
  logic [NUM_FFLAGS-1:0] fflags_nxt;

  assign retire_flags = {flag_nv, flag_dz, flag_of, flag_uf, flag_nx};

  always_comb begin
    fflags_nxt = wr_en ? wr_data : fflags;
    // Flags of a bubble are meaningless, only valid entries accrue
    if (valid) begin
      fflags_nxt = fflags_nxt | retire_flags;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fflags <= '0;
    end else begin
      fflags <= fflags_nxt;
    end
  end

endmodule

// ==== src/fp_regfile.sv ====
// Floating-point register file
// f0..f31 at FLEN bits, one write port and one combinational read port
`timescale 1ns/10ps

module fp_regfile
  import wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  we,
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic [FLEN-1:0]       wdata,    // Already NaN boxed for singles
  input  logic [REG_ADDR_W-1:0] rs_addr,
  output logic [FLEN-1:0]       rs_data
);

  localparam int NUM_REGS = 1 << REG_ADDR_W;

  logic [FLEN-1:0] regs [NUM_REGS];

  // Unlike x0, f0 is an ordinary register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs_data = regs[rs_addr];

endmodule

// ==== src/int_regfile.sv ====
// Integer register file
// x1..x31 with one write port and two combinational read ports,
// x0 reads as zero and ignores writes
`timescale 1ns/10ps

module int_regfile
  import wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  we,
  input  logic [REG_ADDR_W-1:0] waddr,
  input  logic [XLEN-1:0]       wdata,
  input  logic [REG_ADDR_W-1:0] rs1_addr,
  input  logic [REG_ADDR_W-1:0] rs2_addr,
  output logic [XLEN-1:0]       rs1_data,
  output logic [XLEN-1:0]       rs2_data
);

  localparam int NUM_REGS = 1 << REG_ADDR_W;

  logic [XLEN-1:0] regs [1:NUM_REGS-1];  // No storage behind x0

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // No write-to-read bypass, a new value shows after the edge
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1_addr != '0) begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr != '0) begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

// ==== src/wb_select.sv ====
// Write-back selector
// Picks the integer result by wb_sel, builds the FP write word with
// NaN boxing for singles and qualifies both write enables with valid
`timescale 1ns/10ps

module wb_select
  import wb_pkg::*;
(
  input  logic [XLEN-1:0]       alu_result,
  input  logic [XLEN-1:0]       mem_read_data,
  input  logic [FLEN-1:0]       fp_mem_read_data,
  input  logic [REG_ADDR_W-1:0] rd_addr,
  input  logic [XLEN-1:0]       pc_plus_4,
  input  logic                  reg_write,
  input  logic [WB_SEL_W-1:0]   wb_sel,
  input  logic                  valid,
  input  logic [XLEN-1:0]       mul_div_result,
  input  logic [XLEN-1:0]       atomic_result,
  input  logic [FLEN-1:0]       fp_result,
  input  logic [XLEN-1:0]       int_result_fp,
  input  logic [REG_ADDR_W-1:0] fp_rd_addr,
  input  logic                  fp_reg_write,
  input  logic                  int_reg_write_fp,
  input  logic                  fp_fmt,
  input  logic [XLEN-1:0]       csr_rdata,

  output logic                  int_we,
  output logic [REG_ADDR_W-1:0] int_waddr,
  output logic [XLEN-1:0]       int_wdata,
  output logic                  fp_we,
  output logic [REG_ADDR_W-1:0] fp_waddr,
  output logic [FLEN-1:0]       fp_wdata
);

  fp_word_u fp_word;

  // FP compares, classify and moves to int also write rd
  assign int_we    = valid & (reg_write | int_reg_write_fp);
  assign int_waddr = rd_addr;

  always_comb begin
    case (wb_sel)
      WB_SEL_ALU:    int_wdata = alu_result;
      WB_SEL_MEM:    int_wdata = mem_read_data;
      WB_SEL_PC4:    int_wdata = pc_plus_4;
      WB_SEL_CSR:    int_wdata = csr_rdata;
      WB_SEL_MULDIV: int_wdata = mul_div_result;
      WB_SEL_ATOMIC: int_wdata = atomic_result;
      WB_SEL_FPINT:  int_wdata = int_result_fp;
      default:       int_wdata = '0;  // Unused code
    endcase
  end

  // FLW/FLD take the load data, every other FP op its own result
  always_comb begin
    fp_word.dbl = (wb_sel == WB_SEL_MEM) ? fp_mem_read_data : fp_result;
    if (!fp_fmt) begin
      fp_word.sgl.box = '1;  // NaN box
    end
  end

  assign fp_we    = valid & fp_reg_write;
  assign fp_waddr = fp_rd_addr;
  assign fp_wdata = fp_word.dbl;

endmodule

// ==== src/memwb_register.sv ====
// MEM/WB pipeline register
// Captures every memory-stage result on each rising edge for write-back
// Last stage of the pipe, so there is no stall or flush
`timescale 1ns/10ps

module memwb_register
  import wb_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_n,

  // Memory-stage results
  input  logic [XLEN-1:0]       alu_result_in,
  input  logic [XLEN-1:0]       mem_read_data_in,
  input  logic [FLEN-1:0]       fp_mem_read_data_in,  // Full FLD data
  input  logic [REG_ADDR_W-1:0] rd_addr_in,
  input  logic [XLEN-1:0]       pc_plus_4_in,
  input  logic                  reg_write_in,
  input  logic [WB_SEL_W-1:0]   wb_sel_in,
  input  logic                  valid_in,
  input  logic [XLEN-1:0]       mul_div_result_in,
  input  logic [XLEN-1:0]       atomic_result_in,
  input  logic [FLEN-1:0]       fp_result_in,
  input  logic [XLEN-1:0]       int_result_fp_in,
  input  logic [REG_ADDR_W-1:0] fp_rd_addr_in,
  input  logic                  fp_reg_write_in,
  input  logic                  int_reg_write_fp_in,
  input  logic                  fp_flag_nv_in,
  input  logic                  fp_flag_dz_in,
  input  logic                  fp_flag_of_in,
  input  logic                  fp_flag_uf_in,
  input  logic                  fp_flag_nx_in,
  input  logic                  fp_fmt_in,            // 0 single, 1 double
  input  logic [XLEN-1:0]       csr_rdata_in,

  // Registered copies for the write-back logic
  output logic [XLEN-1:0]       alu_result_out,
  output logic [XLEN-1:0]       mem_read_data_out,
  output logic [FLEN-1:0]       fp_mem_read_data_out,
  output logic [REG_ADDR_W-1:0] rd_addr_out,
  output logic [XLEN-1:0]       pc_plus_4_out,
  output logic                  reg_write_out,
  output logic [WB_SEL_W-1:0]   wb_sel_out,
  output logic                  valid_out,
  output logic [XLEN-1:0]       mul_div_result_out,
  output logic [XLEN-1:0]       atomic_result_out,
  output logic [FLEN-1:0]       fp_result_out,
  output logic [XLEN-1:0]       int_result_fp_out,
  output logic [REG_ADDR_W-1:0] fp_rd_addr_out,
  output logic                  fp_reg_write_out,
  output logic                  int_reg_write_fp_out,
  output logic                  fp_flag_nv_out,
  output logic                  fp_flag_dz_out,
  output logic                  fp_flag_of_out,
  output logic                  fp_flag_uf_out,
  output logic                  fp_flag_nx_out,
  output logic                  fp_fmt_out,
  output logic [XLEN-1:0]       csr_rdata_out
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      // Empty stage out of reset, nothing retires
      valid_out            <= 1'b0;
      reg_write_out        <= 1'b0;
      fp_reg_write_out     <= 1'b0;
      int_reg_write_fp_out <= 1'b0;
      wb_sel_out           <= WB_SEL_ALU;
      rd_addr_out          <= '0;
      fp_rd_addr_out       <= '0;
      fp_fmt_out           <= 1'b0;
      fp_flag_nv_out       <= 1'b0;
      fp_flag_dz_out       <= 1'b0;
      fp_flag_of_out       <= 1'b0;
      fp_flag_uf_out       <= 1'b0;
      fp_flag_nx_out       <= 1'b0;
      alu_result_out       <= '0;
      mem_read_data_out    <= '0;
      fp_mem_read_data_out <= '0;
      pc_plus_4_out        <= '0;
      mul_div_result_out   <= '0;
      atomic_result_out    <= '0;
      fp_result_out        <= '0;
      int_result_fp_out    <= '0;
      csr_rdata_out        <= '0;
    end else begin
      valid_out            <= valid_in;
      reg_write_out        <= reg_write_in;
      fp_reg_write_out     <= fp_reg_write_in;
      int_reg_write_fp_out <= int_reg_write_fp_in;
      wb_sel_out           <= wb_sel_in;
      rd_addr_out          <= rd_addr_in;
      fp_rd_addr_out       <= fp_rd_addr_in;
      fp_fmt_out           <= fp_fmt_in;
      fp_flag_nv_out       <= fp_flag_nv_in;
      fp_flag_dz_out       <= fp_flag_dz_in;
      fp_flag_of_out       <= fp_flag_of_in;
      fp_flag_uf_out       <= fp_flag_uf_in;
      fp_flag_nx_out       <= fp_flag_nx_in;
      alu_result_out       <= alu_result_in;
      mem_read_data_out    <= mem_read_data_in;
      fp_mem_read_data_out <= fp_mem_read_data_in;
      pc_plus_4_out        <= pc_plus_4_in;
      mul_div_result_out   <= mul_div_result_in;
      atomic_result_out    <= atomic_result_in;
      fp_result_out        <= fp_result_in;
      int_result_fp_out    <= int_result_fp_in;
      csr_rdata_out        <= csr_rdata_in;
    end
  end

endmodule

// ==== src/wb_pkg.sv ====
// Write-back stage package
// Widths, write-back source select codes and the floating-point
// write word shared by the MEM/WB end of the RV32D core
package wb_pkg;

  // Core widths, fixed at RV32D
  localparam int XLEN       = 32;
  localparam int FLEN       = 64;
  localparam int REG_ADDR_W = 5;

  // Write-back source select
  localparam int WB_SEL_W = 3;

  localparam logic [WB_SEL_W-1:0] WB_SEL_ALU    = 3'd0;
  localparam logic [WB_SEL_W-1:0] WB_SEL_MEM    = 3'd1;  // Load data
  localparam logic [WB_SEL_W-1:0] WB_SEL_PC4    = 3'd2;  // Link address for JAL/JALR
  localparam logic [WB_SEL_W-1:0] WB_SEL_CSR    = 3'd3;
  localparam logic [WB_SEL_W-1:0] WB_SEL_MULDIV = 3'd4;
  localparam logic [WB_SEL_W-1:0] WB_SEL_ATOMIC = 3'd5;
  localparam logic [WB_SEL_W-1:0] WB_SEL_FPINT  = 3'd6;  // FP op with integer result

  // Accrued exception flags, ordered NV DZ OF UF NX from high to low
  localparam int NUM_FFLAGS = 5;

  // Single-precision view of an FP register word
  typedef struct packed {
    logic [FLEN-XLEN-1:0] box;    // All ones for a legal NaN-boxed single
    logic [XLEN-1:0]      value;
  } fp_sgl_t;

  // One FP register word, read as a double or as a boxed single
  typedef union packed {
    logic [FLEN-1:0] dbl;
    fp_sgl_t         sgl;
  } fp_word_u;

endpackage
